//--- Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_rob -f tb.f -o tb_rob
	./obj_dir/tb_rob | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- rtl/rob_commit_ctrl.sv
module rob_commit_ctrl (
  input  logic                    global_bus,
  input  logic                    rst_n,
  input  rob_pkg::record_status_e head_status,
  input  logic                    head_jumps,
  input  logic                    head_jump_taken,
  input  rob_pkg::xlen_t          head_jmp_address,
  input  logic                    commit_ready,
  output logic                    commit_valid,
  output logic                    pop,
  output logic                    flush,
  output logic                    issue_ready_en,
  output logic                    pc_write,
  output rob_pkg::xlen_t          redirect_address,
  output logic                    clear_tag,
  output logic                    delete_tag
);

  typedef enum logic {
    RUN,
    FLUSH
  } commit_state_e;

  commit_state_e state;
  commit_state_e state_next;
  logic          retire;
  logic          mispredict;
  logic          predicted;

  assign commit_valid = (state == RUN) && (head_status == rob_pkg::COMPLETED);
  assign retire       = commit_valid && commit_ready;
  assign mispredict   = retire && head_jumps && head_jump_taken;
  assign predicted    = retire && head_jumps && !head_jump_taken;

  assign pop            = retire;
  assign flush          = mispredict; // Truncates the tail on the same edge.
  assign issue_ready_en = (state == RUN);

  always_comb begin
    state_next = state;
    case (state)
      RUN:   if (mispredict) state_next = FLUSH;
      FLUSH: state_next = RUN; // Single redirect cycle.
      default: state_next = RUN;
    endcase
  end

  always_ff @(posedge global_bus or negedge rst_n) begin
    if (!rst_n) begin
      state      <= RUN;
      pc_write   <= 1'b0;
      delete_tag <= 1'b0;
      clear_tag  <= 1'b0;
    end else begin
      state      <= state_next;
      pc_write   <= mispredict;
      delete_tag <= mispredict;
      clear_tag  <= predicted;
    end
  end

  always_ff @(posedge global_bus) begin
    if (mispredict) redirect_address <= head_jmp_address;
  end

  // A redirect always discards the younger records.
  a_redirect_deletes: assert property (
    @(posedge global_bus) disable iff (!rst_n)
    pc_write |-> delete_tag
  ) else $error("pc_write without delete_tag.");

endmodule

//--- rtl/rob_pkg.sv
package rob_pkg;

  // Machine word for addresses, results and jump targets.
  typedef logic [31:0] xlen_t;

  // Architectural register number.
  typedef logic [4:0] arn_t;

  // Renamed register number.
  typedef logic [5:0] rrn_t;

  typedef enum logic [1:0] {
    EMPTY,
    WAITING,
    COMPLETED
  } record_status_e;

endpackage

//--- rtl/rob_pointers.sv
module rob_pointers #(
  parameter int SIZE = 16,
  parameter int PTR_W = 4
) (
  input  logic             global_bus,
  input  logic             rst_n,
  input  logic             push0,
  input  logic             push1,
  input  logic             pop,
  input  logic             flush,
  output logic [PTR_W-1:0] head,
  output logic [PTR_W-1:0] tail,
  output logic [PTR_W:0]   count,
  output logic             full,
  output logic             empty
);

  logic [1:0]       push_cnt;
  logic [PTR_W-1:0] head_next;
  logic [PTR_W:0]   count_next;

  assign push_cnt = {1'b0, push0} + {1'b0, push1};
  assign head_next = head + PTR_W'(pop);

  always_comb begin
    count_next = count + (PTR_W + 1)'(push_cnt);
    count_next = count_next - (PTR_W + 1)'(pop);
  end

  always_ff @(posedge global_bus or negedge rst_n) begin
    if (!rst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      head <= head_next;
      if (flush) begin
        // Everything behind the retiring jump is discarded.
        tail  <= head_next;
        count <= '0;
      end else begin
        tail  <= tail + PTR_W'(push_cnt);
        count <= count_next;
      end
    end
  end

  assign full  = (count == (PTR_W + 1)'(SIZE));
  assign empty = (count == '0);

  a_count_bound: assert property (
    @(posedge global_bus) disable iff (!rst_n)
    count <= (PTR_W + 1)'(SIZE)
  ) else $error("Occupancy above SIZE.");

  // The controller must only retire a record that exists.
  a_pop_not_empty: assert property (
    @(posedge global_bus) disable iff (!rst_n)
    pop |-> !empty
  ) else $error("Pop on empty buffer.");

endmodule

//--- rtl/rob_records.sv
module rob_records #(
  parameter int SIZE = 16,
  parameter int PTR_W = 4
) (
  input  logic                     global_bus,
  input  logic                     rst_n,
  input  rob_pkg::xlen_t           issue0_address,
  input  rob_pkg::arn_t            issue0_arn,
  input  rob_pkg::rrn_t            issue0_rrn,
  input  logic                     issue0_jumps,
  input  logic                     issue0_writes,
  input  logic                     issue0_mem,
  input  rob_pkg::xlen_t           issue1_address,
  input  rob_pkg::arn_t            issue1_arn,
  input  rob_pkg::rrn_t            issue1_rrn,
  input  logic                     issue1_jumps,
  input  logic                     issue1_writes,
  input  logic                     issue1_mem,
  input  logic                     push0,
  input  logic                     push1,
  input  logic [PTR_W-1:0]         tail,
  input  logic                     cdb0_valid,
  input  rob_pkg::xlen_t           cdb0_address,
  input  rob_pkg::xlen_t           cdb0_result,
  input  rob_pkg::xlen_t           cdb0_jmp_address,
  input  logic                     cdb1_valid,
  input  rob_pkg::xlen_t           cdb1_address,
  input  rob_pkg::xlen_t           cdb1_result,
  input  rob_pkg::xlen_t           cdb1_jmp_address,
  input  logic [PTR_W-1:0]         head,
  input  logic                     pop,
  input  logic                     flush,
  output rob_pkg::record_status_e  head_status,
  output rob_pkg::xlen_t           head_address,
  output rob_pkg::xlen_t           head_result,
  output rob_pkg::xlen_t           head_jmp_address,
  output rob_pkg::arn_t            head_arn,
  output rob_pkg::rrn_t            head_rrn,
  output logic                     head_jumps,
  output logic                     head_writes,
  output logic                     head_mem,
  output logic                     head_jump_taken
);

  rob_pkg::record_status_e status [SIZE];
  rob_pkg::xlen_t          address [SIZE];
  rob_pkg::xlen_t          result [SIZE];
  rob_pkg::xlen_t          jmp_address [SIZE];
  rob_pkg::arn_t           arn [SIZE];
  rob_pkg::rrn_t           rrn [SIZE];
  logic                    jumps [SIZE];
  logic                    writes [SIZE];
  logic                    mem [SIZE];

  logic [SIZE-1:0]  match0;
  logic [SIZE-1:0]  match1;
  logic [PTR_W-1:0] slot1;

  // Lane 1 lands behind lane 0 only when both issue.
  assign slot1 = tail + PTR_W'(push0);

  always_comb begin
    for (int i = 0; i < SIZE; i++) begin
      match0[i] = cdb0_valid && (status[i] == rob_pkg::WAITING) && (address[i] == cdb0_address);
      match1[i] = cdb1_valid && (status[i] == rob_pkg::WAITING) && (address[i] == cdb1_address);
    end
  end

  always_ff @(posedge global_bus or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < SIZE; i++) status[i] <= rob_pkg::EMPTY;
    end else if (flush) begin
      for (int i = 0; i < SIZE; i++) status[i] <= rob_pkg::EMPTY;
    end else begin
      for (int i = 0; i < SIZE; i++) begin
        if (match0[i] || match1[i]) status[i] <= rob_pkg::COMPLETED;
      end
      if (pop) status[head] <= rob_pkg::EMPTY; // Retired slot freed.
      if (push0) status[tail] <= rob_pkg::WAITING;
      if (push1) status[slot1] <= rob_pkg::WAITING;
    end
  end

  always_ff @(posedge global_bus) begin
    if (push0) begin
      address[tail] <= issue0_address;
      arn[tail]     <= issue0_arn;
      rrn[tail]     <= issue0_rrn;
      jumps[tail]   <= issue0_jumps;
      writes[tail]  <= issue0_writes;
      mem[tail]     <= issue0_mem;
    end
    if (push1) begin
      address[slot1] <= issue1_address;
      arn[slot1]     <= issue1_arn;
      rrn[slot1]     <= issue1_rrn;
      jumps[slot1]   <= issue1_jumps;
      writes[slot1]  <= issue1_writes;
      mem[slot1]     <= issue1_mem;
    end
    for (int i = 0; i < SIZE; i++) begin
      if (match0[i]) begin
        result[i]      <= cdb0_result;
        jmp_address[i] <= cdb0_jmp_address;
      end
      if (match1[i]) begin
        result[i]      <= cdb1_result;
        jmp_address[i] <= cdb1_jmp_address;
      end
    end
  end

  assign head_status      = status[head];
  assign head_address     = address[head];
  assign head_result      = result[head];
  assign head_jmp_address = jmp_address[head];
  assign head_arn         = arn[head];
  assign head_rrn         = rrn[head];
  assign head_jumps       = jumps[head];
  assign head_writes      = writes[head];
  assign head_mem         = mem[head];

  // Fall-through was the guess.
  assign head_jump_taken = (head_jmp_address != head_address + 32'd4);

  a_unique_match: assert property (
    @(posedge global_bus) disable iff (!rst_n)
    $onehot0(match0) && $onehot0(match1)
  ) else $error("Completion matched several records.");

endmodule

//--- rtl/rob_top.sv
module rob_top #(
  parameter int SIZE = 16,
  parameter int PTR_W = $clog2(SIZE)
) (
  input  logic           global_bus,
  input  logic           rst_n,
  input  logic           issue0_valid,
  input  rob_pkg::xlen_t issue0_address,
  input  rob_pkg::arn_t  issue0_arn,
  input  rob_pkg::rrn_t  issue0_rrn,
  input  logic           issue0_jumps,
  input  logic           issue0_writes,
  input  logic           issue0_mem,
  input  logic           issue1_valid,
  input  rob_pkg::xlen_t issue1_address,
  input  rob_pkg::arn_t  issue1_arn,
  input  rob_pkg::rrn_t  issue1_rrn,
  input  logic           issue1_jumps,
  input  logic           issue1_writes,
  input  logic           issue1_mem,
  output logic           issue_ready,
  input  logic           cdb0_valid,
  input  rob_pkg::xlen_t cdb0_address,
  input  rob_pkg::xlen_t cdb0_result,
  input  rob_pkg::xlen_t cdb0_jmp_address,
  input  logic           cdb1_valid,
  input  rob_pkg::xlen_t cdb1_address,
  input  rob_pkg::xlen_t cdb1_result,
  input  rob_pkg::xlen_t cdb1_jmp_address,
  output logic           commit_valid,
  input  logic           commit_ready,
  output rob_pkg::xlen_t commit_address,
  output rob_pkg::xlen_t commit_result,
  output rob_pkg::arn_t  commit_arn,
  output rob_pkg::rrn_t  commit_rrn,
  output logic           commit_reg_write,
  output logic           commit_cache_write,
  output logic           commit_jump,
  output logic           pc_write,
  output rob_pkg::xlen_t redirect_address,
  output logic           clear_tag,
  output logic           delete_tag
);

  logic                    push0;
  logic                    push1;
  logic                    pop;
  logic                    flush;
  logic                    issue_ready_en;
  logic [PTR_W-1:0]        head;
  logic [PTR_W-1:0]        tail;
  logic [PTR_W:0]          count;
  logic                    empty;
  rob_pkg::record_status_e head_status;
  rob_pkg::xlen_t          head_jmp_address;
  logic                    head_mem;
  logic                    head_jump_taken;

  // Room for two records keeps both lanes simple.
  assign issue_ready = rst_n && issue_ready_en && (count <= (PTR_W + 1)'(SIZE - 2));
  assign push0       = issue0_valid && issue_ready;
  assign push1       = issue1_valid && issue_ready;

  assign commit_cache_write = head_mem && commit_reg_write;

  rob_pointers #(.SIZE(SIZE), .PTR_W(PTR_W)) i_pointers (
    .global_bus, .rst_n, .push0, .push1, .pop, .flush,
    .head, .tail, .count, .full(), .empty
  );

  rob_records #(.SIZE(SIZE), .PTR_W(PTR_W)) i_records (
    .global_bus, .rst_n,
    .issue0_address, .issue0_arn, .issue0_rrn, .issue0_jumps, .issue0_writes, .issue0_mem,
    .issue1_address, .issue1_arn, .issue1_rrn, .issue1_jumps, .issue1_writes, .issue1_mem,
    .push0, .push1, .tail,
    .cdb0_valid, .cdb0_address, .cdb0_result, .cdb0_jmp_address,
    .cdb1_valid, .cdb1_address, .cdb1_result, .cdb1_jmp_address,
    .head, .pop, .flush,
    .head_status,
    .head_address     (commit_address),
    .head_result      (commit_result),
    .head_jmp_address,
    .head_arn         (commit_arn),
    .head_rrn         (commit_rrn),
    .head_jumps       (commit_jump),
    .head_writes      (commit_reg_write),
    .head_mem,
    .head_jump_taken
  );

  rob_commit_ctrl i_ctrl (
    .global_bus, .rst_n,
    .head_status, .head_jumps(commit_jump), .head_jump_taken, .head_jmp_address,
    .commit_ready, .commit_valid, .pop, .flush, .issue_ready_en,
    .pc_write, .redirect_address, .clear_tag, .delete_tag
  );

  a_commit_has_record: assert property (
    @(posedge global_bus) disable iff (!rst_n)
    commit_valid |-> !empty
  ) else $error("Commit offered from an empty buffer.");

endmodule

//--- tb.f
rtl/rob_pkg.sv
rtl/rob_pointers.sv
rtl/rob_records.sv
rtl/rob_commit_ctrl.sv
rtl/rob_top.sv
test/tb_rob.sv

//--- test/tb_rob.sv
module tb_rob;

  localparam int SIZE = 16;
  localparam int N_ROWS = 34;
  localparam int STALL_ROW = 14;
  localparam int LIMIT = N_ROWS * 40;

  logic           global_bus;
  logic           rst_n;
  logic           issue0_valid;
  rob_pkg::xlen_t issue0_address;
  rob_pkg::arn_t  issue0_arn;
  rob_pkg::rrn_t  issue0_rrn;
  logic           issue0_jumps;
  logic           issue0_writes;
  logic           issue0_mem;
  logic           issue1_valid;
  rob_pkg::xlen_t issue1_address;
  rob_pkg::arn_t  issue1_arn;
  rob_pkg::rrn_t  issue1_rrn;
  logic           issue1_jumps;
  logic           issue1_writes;
  logic           issue1_mem;
  logic           issue_ready;
  logic           cdb0_valid;
  rob_pkg::xlen_t cdb0_address;
  rob_pkg::xlen_t cdb0_result;
  rob_pkg::xlen_t cdb0_jmp_address;
  logic           cdb1_valid;
  rob_pkg::xlen_t cdb1_address;
  rob_pkg::xlen_t cdb1_result;
  rob_pkg::xlen_t cdb1_jmp_address;
  logic           commit_valid;
  logic           commit_ready;
  rob_pkg::xlen_t commit_address;
  rob_pkg::xlen_t commit_result;
  rob_pkg::arn_t  commit_arn;
  rob_pkg::rrn_t  commit_rrn;
  logic           commit_reg_write;
  logic           commit_cache_write;
  logic           commit_jump;
  logic           pc_write;
  rob_pkg::xlen_t redirect_address;
  logic           clear_tag;
  logic           delete_tag;

  // Program table, one entry per instruction.
  rob_pkg::xlen_t row_addr [N_ROWS];
  rob_pkg::arn_t  row_arn [N_ROWS];
  rob_pkg::rrn_t  row_rrn [N_ROWS];
  logic           row_jump [N_ROWS];
  logic           row_write [N_ROWS];
  logic           row_mem [N_ROWS];
  rob_pkg::xlen_t row_result [N_ROWS];
  rob_pkg::xlen_t row_target [N_ROWS];
  int             row_delay [N_ROWS];
  int             due [N_ROWS];
  bit             done [N_ROWS];

  int q [$];        // Rows in program order, not yet retired.
  int pending [$];  // Rows still waiting for their completion.
  int last_cdb [$];
  int n_loaded, next_row, cyc, low_cycles;
  int errors, commits, clears, redirects;
  logic [31:0] lcg_state;
  bit exp_redirect, exp_clear, model_valid, model_ready;
  bit stall, stall_done, finished;
  rob_pkg::xlen_t exp_target;

  rob_top #(.SIZE(SIZE)) i_dut (.*);

  always #2 global_bus = ~global_bus;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("FAIL %s expected %h actual %h (cycle %0d)", name, exp, act, cyc);
    errors++;
  endtask

  task automatic add_row(input rob_pkg::xlen_t addr, input rob_pkg::arn_t arn,
                         input rob_pkg::rrn_t rrn, input logic j, input logic w, input logic m,
                         input rob_pkg::xlen_t result, input rob_pkg::xlen_t target,
                         input int delay);
    row_addr[n_loaded]   = addr;
    row_arn[n_loaded]    = arn;
    row_rrn[n_loaded]    = rrn;
    row_jump[n_loaded]   = j;
    row_write[n_loaded]  = w;
    row_mem[n_loaded]    = m;
    row_result[n_loaded] = result;
    row_target[n_loaded] = target;
    row_delay[n_loaded]  = delay;
    done[n_loaded]       = 1'b0;
    n_loaded++;
  endtask

  task automatic load_table();
    //      address       arn    rrn    j  w  m  result        target        delay
    add_row(32'h0000_0100, 5'd1,  6'd33, 0, 1, 0, 32'ha000_0000, 32'h0,        3);
    add_row(32'h0000_0104, 5'd2,  6'd34, 0, 1, 0, 32'ha000_0001, 32'h0,        1);
    add_row(32'h0000_0108, 5'd3,  6'd35, 0, 1, 1, 32'ha000_0002, 32'h0,        5);
    add_row(32'h0000_010c, 5'd1,  6'd36, 1, 1, 0, 32'ha000_0003, 32'h0000_0110, 2);
    add_row(32'h0000_0110, 5'd4,  6'd37, 0, 0, 1, 32'ha000_0004, 32'h0,        1);
    add_row(32'h0000_0114, 5'd5,  6'd38, 0, 1, 0, 32'ha000_0005, 32'h0,        6);
    add_row(32'h0000_0118, 5'd6,  6'd39, 0, 0, 0, 32'ha000_0006, 32'h0,        2);
    add_row(32'h0000_011c, 5'd1,  6'd40, 1, 1, 0, 32'ha000_0007, 32'h0000_0300, 1);
    add_row(32'h0000_0120, 5'd7,  6'd41, 0, 1, 0, 32'ha000_0008, 32'h0,        4);
    add_row(32'h0000_0124, 5'd8,  6'd42, 0, 1, 1, 32'ha000_0009, 32'h0,        2);
    add_row(32'h0000_0128, 5'd9,  6'd43, 0, 1, 0, 32'ha000_000a, 32'h0,        7);
    add_row(32'h0000_012c, 5'd10, 6'd44, 0, 0, 1, 32'ha000_000b, 32'h0,        1);
    add_row(32'h0000_0130, 5'd11, 6'd45, 0, 1, 0, 32'ha000_000c, 32'h0,        3);
    add_row(32'h0000_0134, 5'd12, 6'd46, 0, 1, 0, 32'ha000_000d, 32'h0,        2);
    add_row(32'h0000_0138, 5'd13, 6'd47, 0, 1, 1, 32'ha000_000e, 32'h0,        5);
    add_row(32'h0000_013c, 5'd14, 6'd48, 0, 1, 0, 32'ha000_000f, 32'h0,        1);
    add_row(32'h0000_0140, 5'd15, 6'd49, 0, 0, 0, 32'ha000_0010, 32'h0,        8);
    add_row(32'h0000_0144, 5'd16, 6'd50, 0, 1, 0, 32'ha000_0011, 32'h0,        2);
    add_row(32'h0000_0148, 5'd17, 6'd51, 0, 1, 1, 32'ha000_0012, 32'h0,        3);
    add_row(32'h0000_014c, 5'd18, 6'd52, 0, 1, 0, 32'ha000_0013, 32'h0,        1);
    add_row(32'h0000_0150, 5'd19, 6'd53, 0, 0, 1, 32'ha000_0014, 32'h0,        4);
    add_row(32'h0000_0154, 5'd20, 6'd54, 0, 1, 0, 32'ha000_0015, 32'h0,        6);
    add_row(32'h0000_0158, 5'd1,  6'd55, 1, 1, 0, 32'ha000_0016, 32'h0000_015c, 2);
    add_row(32'h0000_015c, 5'd21, 6'd56, 0, 1, 0, 32'ha000_0017, 32'h0,        1);
    add_row(32'h0000_0160, 5'd22, 6'd57, 0, 1, 1, 32'ha000_0018, 32'h0,        3);
    add_row(32'h0000_0164, 5'd23, 6'd58, 0, 1, 0, 32'ha000_0019, 32'h0,        5);
    add_row(32'h0000_0168, 5'd24, 6'd59, 0, 0, 0, 32'ha000_001a, 32'h0,        2);
    add_row(32'h0000_016c, 5'd25, 6'd60, 0, 1, 0, 32'ha000_001b, 32'h0,        1);
    add_row(32'h0000_0170, 5'd26, 6'd61, 0, 1, 1, 32'ha000_001c, 32'h0,        4);
    add_row(32'h0000_0174, 5'd1,  6'd62, 1, 1, 0, 32'ha000_001d, 32'h0000_0500, 2);
    add_row(32'h0000_0178, 5'd27, 6'd63, 0, 1, 0, 32'ha000_001e, 32'h0,        3);
    add_row(32'h0000_017c, 5'd28, 6'd32, 0, 1, 0, 32'ha000_001f, 32'h0,        1);
    add_row(32'h0000_0180, 5'd29, 6'd31, 0, 0, 1, 32'ha000_0020, 32'h0,        2);
    add_row(32'h0000_0184, 5'd30, 6'd30, 0, 1, 0, 32'ha000_0021, 32'h0,        1);
  endtask

  task automatic check_outputs();
    model_valid = 1'b0;
    if (!exp_redirect && q.size() > 0) model_valid = done[q[0]];
    model_ready = !exp_redirect && (q.size() <= SIZE - 2);
    if (commit_valid !== model_valid) report_mismatch("commit_valid", model_valid, commit_valid);
    if (issue_ready !== model_ready) report_mismatch("issue_ready", model_ready, issue_ready);
    if (pc_write !== exp_redirect) report_mismatch("pc_write", exp_redirect, pc_write);
    if (delete_tag !== exp_redirect) report_mismatch("delete_tag", exp_redirect, delete_tag);
    if (clear_tag !== exp_clear) report_mismatch("clear_tag", exp_clear, clear_tag);
    if (exp_redirect && redirect_address !== exp_target) begin
      report_mismatch("redirect_address", exp_target, redirect_address);
    end
    if (clear_tag === 1'b1) clears++;
    if (pc_write === 1'b1) redirects++;
  endtask

  // Holds the commit port until the buffer refuses further issues.
  task automatic update_stall();
    if (!stall_done && !stall && next_row >= STALL_ROW) stall = 1'b1;
    if (stall) begin
      if (!exp_redirect && !issue_ready) low_cycles++;
      if (low_cycles >= 8) begin
        stall = 1'b0;
        stall_done = 1'b1;
      end else if (next_row >= N_ROWS && issue_ready) begin
        $display("ERROR: issue_ready did not drop while commit_ready was held low");
        errors++;
        stall = 1'b0;
        stall_done = 1'b1;
      end
    end
  endtask

  task automatic commit_step();
    int r;
    exp_redirect = 1'b0;
    exp_clear = 1'b0;
    lcg_state = lcg_next(lcg_state);
    commit_ready = !stall && (lcg_state[17:16] != 2'b00);
    if (model_valid && commit_ready) begin
      r = q.pop_front();
      if (commit_address !== row_addr[r]) begin
        report_mismatch("commit_address", row_addr[r], commit_address);
      end
      if (commit_result !== row_result[r]) begin
        report_mismatch("commit_result", row_result[r], commit_result);
      end
      if (commit_arn !== row_arn[r]) report_mismatch("commit_arn", row_arn[r], commit_arn);
      if (commit_rrn !== row_rrn[r]) report_mismatch("commit_rrn", row_rrn[r], commit_rrn);
      if (commit_reg_write !== row_write[r]) begin
        report_mismatch("commit_reg_write", row_write[r], commit_reg_write);
      end
      if (commit_cache_write !== (row_mem[r] & row_write[r])) begin
        report_mismatch("commit_cache_write", row_mem[r] & row_write[r], commit_cache_write);
      end
      if (commit_jump !== row_jump[r]) report_mismatch("commit_jump", row_jump[r], commit_jump);
      commits++;
      if (row_jump[r]) begin
        if (row_target[r] == row_addr[r] + 32'd4) begin
          exp_clear = 1'b1;
        end else begin
          exp_redirect = 1'b1;
          exp_target = row_target[r];
          q.delete(); // Younger records are discarded.
        end
      end
    end
  endtask

  task automatic drive_issue(input int lane, input int r);
    if (lane == 0) begin
      issue0_valid   = 1'b1;
      issue0_address = row_addr[r];
      issue0_arn     = row_arn[r];
      issue0_rrn     = row_rrn[r];
      issue0_jumps   = row_jump[r];
      issue0_writes  = row_write[r];
      issue0_mem     = row_mem[r];
    end else begin
      issue1_valid   = 1'b1;
      issue1_address = row_addr[r];
      issue1_arn     = row_arn[r];
      issue1_rrn     = row_rrn[r];
      issue1_jumps   = row_jump[r];
      issue1_writes  = row_write[r];
      issue1_mem     = row_mem[r];
    end
    // Rows accepted on the flush edge never reach the buffer.
    if (!exp_redirect) q.push_back(r);
    due[r] = cyc + row_delay[r];
    pending.push_back(r);
    next_row++;
  endtask

  task automatic issue_step();
    logic [1:0] lanes;
    issue0_valid = 1'b0;
    issue1_valid = 1'b0;
    lcg_state = lcg_next(lcg_state);
    lanes = lcg_state[21:20];
    if (model_ready && next_row < N_ROWS) begin
      if (lanes[0]) drive_issue(0, next_row);
      if (lanes[1] && next_row < N_ROWS) drive_issue(1, next_row);
    end
  endtask

  task automatic complete_step();
    int keep [$];
    int used;
    used = 0;
    cdb0_valid = 1'b0;
    cdb1_valid = 1'b0;
    last_cdb.delete();
    foreach (pending[i]) begin
      if (due[pending[i]] <= cyc && used < 2) begin
        if (used == 0) begin
          cdb0_valid       = 1'b1;
          cdb0_address     = row_addr[pending[i]];
          cdb0_result      = row_result[pending[i]];
          cdb0_jmp_address = row_target[pending[i]];
        end else begin
          cdb1_valid       = 1'b1;
          cdb1_address     = row_addr[pending[i]];
          cdb1_result      = row_result[pending[i]];
          cdb1_jmp_address = row_target[pending[i]];
        end
        last_cdb.push_back(pending[i]);
        used++;
      end else begin
        keep.push_back(pending[i]);
      end
    end
    pending = keep;
  endtask

  initial begin
    global_bus = 1'b0;
    rst_n = 1'b0;
    {issue0_valid, issue0_address, issue0_arn, issue0_rrn} = '0;
    {issue0_jumps, issue0_writes, issue0_mem} = '0;
    {issue1_valid, issue1_address, issue1_arn, issue1_rrn} = '0;
    {issue1_jumps, issue1_writes, issue1_mem} = '0;
    {cdb0_valid, cdb0_address, cdb0_result, cdb0_jmp_address} = '0;
    {cdb1_valid, cdb1_address, cdb1_result, cdb1_jmp_address} = '0;
    commit_ready = 1'b0;
    lcg_state = 32'd76;
    load_table();
    repeat (5) @(posedge global_bus);
    @(negedge global_bus);
    if (commit_valid !== 1'b0) report_mismatch("reset commit_valid", 0, commit_valid);
    if (issue_ready !== 1'b0) report_mismatch("reset issue_ready", 0, issue_ready);
    if (pc_write !== 1'b0) report_mismatch("reset pc_write", 0, pc_write);
    if (clear_tag !== 1'b0) report_mismatch("reset clear_tag", 0, clear_tag);
    if (delete_tag !== 1'b0) report_mismatch("reset delete_tag", 0, delete_tag);
    rst_n = 1'b1;
    while (!finished && cyc < LIMIT) begin
      @(negedge global_bus);
      foreach (last_cdb[i]) done[last_cdb[i]] = 1'b1; // Completed at the last edge.
      check_outputs();
      update_stall();
      commit_step();
      issue_step();
      complete_step();
      cyc++;
      finished = (next_row >= N_ROWS) && (q.size() == 0) && (pending.size() == 0) &&
                 (last_cdb.size() == 0) && !exp_redirect && !exp_clear;
    end
    if (!finished) begin
      $display("ERROR: timeout after %0d cycles with %0d rows issued", cyc, next_row);
      errors++;
    end
    if (clears == 0 || redirects == 0) begin
      $display("ERROR: the run retired no correct jump or no mispredicted jump");
      errors++;
    end
    $display("Summary: %0d commits, %0d clear_tag pulses, %0d redirects, %0d errors",
             commits, clears, redirects, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
